/* rtl/serdes_pkg.sv */
package serdes_pkg;

    localparam int level_w    = 8;  // signed sample width
    localparam int tap_w      = 8;  // signed taps, Q1.6
    localparam int tap_addr_w = 3;  // eight tap words
    localparam int tap_frac   = 6;  // 64 is unity gain
    localparam int level_sep  = 56; // distance between adjacent levels
    localparam int level_max  = 127; // symmetric saturation bound

    // outer and inner level magnitudes, 84 and 28
    localparam int level_outer = level_sep * 3 / 2;
    localparam int level_inner = level_sep / 2;

    typedef struct packed {
        logic                      valid;
        logic signed [level_w-1:0] level;
    } sample_t;

    typedef struct packed {
        logic                  valid;
        logic [tap_addr_w-1:0] addr;
    } tap_req_t;

    typedef struct packed {
        logic                    valid;
        logic signed [tap_w-1:0] tap;
    } tap_rsp_t;

    typedef struct packed {
        logic                    valid;
        logic [tap_addr_w-1:0]   addr;
        logic signed [tap_w-1:0] tap;
    } host_wr_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] bits; // first bit in msb
    } bits_t;

    typedef enum logic [1:0] {
        ld_idle,
        ld_fetch, // requests going out
        ld_drain, // last grant seen, waiting on responses
        ld_ready
    } loader_state_e;

    // symbols in level order, value is the level index
    typedef enum logic [1:0] {
        sym_m3 = 2'b00, // bits 00
        sym_m1 = 2'b01, // bits 01
        sym_p1 = 2'b10, // bits 11
        sym_p3 = 2'b11  // bits 10
    } pam_symbol_e;

    // gray bit pair to level index
    function automatic pam_symbol_e gray_to_symbol(logic [1:0] bits);
        return pam_symbol_e'({bits[1], bits[1] ^ bits[0]});
    endfunction

    // level index back to gray bit pair
    function automatic logic [1:0] symbol_to_gray(pam_symbol_e sym);
        logic [1:0] idx;
        idx = sym;
        return {idx[1], idx[1] ^ idx[0]};
    endfunction

    function automatic logic signed [level_w-1:0] symbol_to_level(pam_symbol_e sym);
        case (sym)
            sym_m3:  return level_w'(-level_outer);
            sym_m1:  return level_w'(-level_inner);
            sym_p1:  return level_w'(level_inner);
            default: return level_w'(level_outer);
        endcase
    endfunction

endpackage

/* rtl/pam4_transmitter.sv */
`timescale 1ns/1ps

module pam4_transmitter import serdes_pkg::*; #(
    parameter logic [6:0] prbs_seed = 7'h7f // must be nonzero
) (
    input  logic    clock,
    input  logic    reset_n,
    input  logic    enable,   // run and taps ready
    output sample_t tx_sample
);

    logic [6:0]                prbs;      // x^7 + x^6 + 1, fibonacci form
    logic                      bit_first; // goes to msb of the pair
    logic                      bit_second;
    pam_symbol_e               sym;
    logic                      out_valid;
    logic signed [level_w-1:0] out_level;

    // two feedback steps unrolled
    assign bit_first  = prbs[6] ^ prbs[5];
    assign bit_second = prbs[5] ^ prbs[4]; // taps after one shift

    assign sym = gray_to_symbol({bit_first, bit_second});

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            prbs      <= prbs_seed;
            out_valid <= 1'b0;
        end else begin
            out_valid <= enable; // one sample per enabled cycle
            if (enable) begin
                prbs <= {prbs[4:0], bit_first, bit_second}; // advance by two
            end
        end
    end

    // level register holds on idle cycles
    always_ff @(posedge clock) begin
        if (enable) begin
            out_level <= symbol_to_level(sym);
        end
    end

    assign tx_sample.valid = out_valid;
    assign tx_sample.level = out_level;

    // seed of zero would lock the generator
    initial begin
        assert (prbs_seed != 7'h00)
            else $error("pam4_transmitter: zero prbs seed");
    end

endmodule

/* rtl/isi_channel.sv */
`timescale 1ns/1ps

module isi_channel import serdes_pkg::*; #(
    parameter int num_channel_taps = 4 // h0 at address 0
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     load_taps,  // restart the tap fetch
    input  sample_t  tx_sample,
    output tap_req_t tap_req,
    input  logic     tap_grant,
    input  tap_rsp_t tap_rsp,
    output logic     taps_loaded,
    output sample_t  channel_out
);

    localparam int idx_w = $clog2(num_channel_taps);
    localparam int acc_w = level_w + tap_w + idx_w; // room for the full sum

    loader_state_e             state;
    logic [idx_w-1:0]          req_idx;  // next address to request
    logic [idx_w-1:0]          rsp_idx;  // next tap slot to fill
    logic                      drop_rsp; // response left over from the old load
    logic                      rsp_take;
    logic signed [tap_w-1:0]   taps [num_channel_taps];
    logic signed [level_w-1:0] x_hist [1:num_channel_taps-1]; // x(n-1) onward
    logic signed [acc_w-1:0]   acc;
    logic signed [acc_w-1:0]   acc_sh;
    logic signed [level_w-1:0] sat_level;
    logic                      accept;
    logic                      out_valid;
    logic signed [level_w-1:0] out_level;

    assign tap_req.valid = (state == ld_fetch);
    assign tap_req.addr  = tap_addr_w'(req_idx);
    assign taps_loaded   = (state == ld_ready);
    assign rsp_take      = tap_rsp.valid & ~drop_rsp & ~load_taps;
    assign accept        = tx_sample.valid & taps_loaded & ~load_taps; // no filtering mid-load

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state    <= ld_idle;
            req_idx  <= '0;
            rsp_idx  <= '0;
            drop_rsp <= 1'b0;
        end else if (load_taps) begin
            state    <= ld_fetch;
            req_idx  <= '0;
            rsp_idx  <= '0;
            drop_rsp <= tap_req.valid & tap_grant; // that read returns next cycle
        end else begin
            drop_rsp <= 1'b0;
            if (state == ld_fetch && tap_grant) begin
                req_idx <= req_idx + 1'b1;
                if (req_idx == idx_w'(num_channel_taps - 1)) begin
                    state <= ld_drain;
                end
            end
            if (rsp_take) begin
                rsp_idx <= rsp_idx + 1'b1;
                if (state == ld_drain && rsp_idx == idx_w'(num_channel_taps - 1)) begin
                    state <= ld_ready; // last tap in
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rsp_take) begin
            taps[rsp_idx] <= tap_rsp.tap; // responses come back in request order
        end
    end

    // fir over current sample and history
    always_comb begin
        acc = taps[0] * tx_sample.level;
        for (int k = 1; k < num_channel_taps; k++) begin
            acc = acc + taps[k] * x_hist[k];
        end
        acc_sh = acc >>> tap_frac; // drop the q1.6 fraction
        if (acc_sh > level_max) begin
            sat_level = level_w'(level_max);
        end else if (acc_sh < -level_max) begin
            sat_level = level_w'(-level_max);
        end else begin
            sat_level = level_w'(acc_sh);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int k = 1; k < num_channel_taps; k++) begin
                x_hist[k] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin // history moves only on valid samples
                x_hist[1] <= tx_sample.level;
                for (int k = 2; k < num_channel_taps; k++) begin
                    x_hist[k] <= x_hist[k-1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_level <= sat_level;
        end
    end

    assign channel_out.valid = out_valid;
    assign channel_out.level = out_level;

    // nothing leaves the channel while a tap load is in progress
    assert property (@(posedge clock) disable iff (!reset_n)
        !taps_loaded |-> !channel_out.valid)
        else $error("isi_channel: output valid while taps not loaded");

endmodule

/* rtl/dfe_receiver.sv */
`timescale 1ns/1ps

module dfe_receiver import serdes_pkg::*; #(
    parameter int num_dfe_taps  = 3,
    parameter int dfe_base_addr = 4 // g1 lives here
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     load_taps,
    input  sample_t  rx_sample,
    output tap_req_t tap_req,
    input  logic     tap_grant,
    input  tap_rsp_t tap_rsp,
    output logic     taps_loaded,
    output bits_t    rx_bits
);

    localparam int idx_w = $clog2(num_dfe_taps);
    localparam int fb_w  = level_w + tap_w + idx_w;
    localparam int eq_w  = fb_w + 1; // input minus feedback

    loader_state_e             state;
    logic [idx_w-1:0]          req_idx;
    logic [idx_w-1:0]          rsp_idx;
    logic                      drop_rsp; // stale read after a restart
    logic                      rsp_take;
    logic signed [tap_w-1:0]   taps [num_dfe_taps];       // g1..gN
    logic signed [level_w-1:0] d_hist [1:num_dfe_taps];   // d(n-1) onward
    logic signed [fb_w-1:0]    fb;
    logic signed [eq_w-1:0]    eq;
    pam_symbol_e               decision;
    logic                      accept;
    logic                      out_valid;
    logic [1:0]                out_bits;

    // nearest level, thresholds at -56, 0, 56
    function automatic pam_symbol_e slice(logic signed [eq_w-1:0] v);
        if (v >= level_sep) begin
            return sym_p3;
        end else if (v >= 0) begin
            return sym_p1;
        end else if (v >= -level_sep) begin
            return sym_m1;
        end
        return sym_m3;
    endfunction

    assign tap_req.valid = (state == ld_fetch);
    assign tap_req.addr  = tap_addr_w'(dfe_base_addr) + tap_addr_w'(req_idx);
    assign taps_loaded   = (state == ld_ready);
    assign rsp_take      = tap_rsp.valid & ~drop_rsp & ~load_taps;
    assign accept        = rx_sample.valid & taps_loaded;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state    <= ld_idle;
            req_idx  <= '0;
            rsp_idx  <= '0;
            drop_rsp <= 1'b0;
        end else if (load_taps) begin // restart from g1
            state    <= ld_fetch;
            req_idx  <= '0;
            rsp_idx  <= '0;
            drop_rsp <= tap_req.valid & tap_grant;
        end else begin
            drop_rsp <= 1'b0;
            if (state == ld_fetch && tap_grant) begin
                req_idx <= req_idx + 1'b1;
                if (req_idx == idx_w'(num_dfe_taps - 1)) begin
                    state <= ld_drain; // all requests granted
                end
            end
            if (rsp_take) begin
                rsp_idx <= rsp_idx + 1'b1;
                if (state == ld_drain && rsp_idx == idx_w'(num_dfe_taps - 1)) begin
                    state <= ld_ready;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rsp_take) begin
            taps[rsp_idx] <= tap_rsp.tap;
        end
    end

    // feedback from past decisions, then slice
    always_comb begin
        fb = '0;
        for (int k = 1; k <= num_dfe_taps; k++) begin
            fb = fb + taps[k-1] * d_hist[k];
        end
        eq       = rx_sample.level - (fb >>> tap_frac);
        decision = slice(eq);
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int k = 1; k <= num_dfe_taps; k++) begin
                d_hist[k] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                d_hist[1] <= symbol_to_level(decision); // ideal level, not eq
                for (int k = 2; k <= num_dfe_taps; k++) begin
                    d_hist[k] <= d_hist[k-1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_bits <= symbol_to_gray(decision);
        end
    end

    assign rx_bits.valid = out_valid;
    assign rx_bits.bits  = out_bits;

endmodule

/* rtl/tap_memory_arbiter.sv */
`timescale 1ns/1ps

module tap_memory_arbiter import serdes_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  host_wr_t host_wr,     // highest priority
    input  tap_req_t channel_req,
    input  tap_req_t dfe_req,     // lowest priority
    output logic     channel_grant,
    output logic     dfe_grant,
    output tap_rsp_t channel_rsp,
    output tap_rsp_t dfe_rsp
);

    logic signed [tap_w-1:0] mem [2**tap_addr_w]; // taps h0..h3, g1..g3, spare
    logic [tap_addr_w-1:0]   rd_addr;
    logic signed [tap_w-1:0] rd_data;
    logic                    ch_rsp_valid;
    logic                    dfe_rsp_valid;

    // fixed priority, host write blocks both reads
    assign channel_grant = channel_req.valid & ~host_wr.valid;
    assign dfe_grant     = dfe_req.valid & ~host_wr.valid & ~channel_req.valid;

    assign rd_addr = channel_grant ? channel_req.addr : dfe_req.addr; // single read port

    always_ff @(posedge clock) begin
        if (host_wr.valid) begin
            mem[host_wr.addr] <= host_wr.tap; // written in the granted cycle
        end
        if (channel_grant || dfe_grant) begin
            rd_data <= mem[rd_addr]; // one cycle read latency
        end
    end

    // response goes to whoever held the grant last cycle
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ch_rsp_valid  <= 1'b0;
            dfe_rsp_valid <= 1'b0;
        end else begin
            ch_rsp_valid  <= channel_grant;
            dfe_rsp_valid <= dfe_grant;
        end
    end

    assign channel_rsp.valid = ch_rsp_valid;
    assign channel_rsp.tap   = rd_data;
    assign dfe_rsp.valid     = dfe_rsp_valid;
    assign dfe_rsp.tap       = rd_data; // shared, only one valid at a time

    assert property (@(posedge clock) disable iff (!reset_n)
        !(channel_grant && dfe_grant) &&
        !(host_wr.valid && (channel_grant || dfe_grant)))
        else $error("tap_memory_arbiter: overlapping grants");

    // loaders must keep asking until served
    assert property (@(posedge clock) disable iff (!reset_n)
        (channel_req.valid && !channel_grant) |=> channel_req.valid)
        else $error("tap_memory_arbiter: channel dropped a pending request");

    assert property (@(posedge clock) disable iff (!reset_n)
        (dfe_req.valid && !dfe_grant) |=> dfe_req.valid)
        else $error("tap_memory_arbiter: dfe dropped a pending request");

endmodule

/* rtl/serdes_link_top.sv */
`timescale 1ns/1ps

module serdes_link_top import serdes_pkg::*; #(
    parameter int         num_channel_taps = 4,
    parameter int         num_dfe_taps     = 3,
    parameter int         dfe_base_addr    = 4,     // after the channel taps
    parameter logic [6:0] prbs_seed        = 7'h7f
) (
    input  logic     clock,
    input  logic     reset_n,
    input  host_wr_t host_wr,    // testbench fills the tap memory
    input  logic     load_taps,  // pulse
    input  logic     run,        // level
    output logic     taps_ready,
    output sample_t  channel_out,
    output bits_t    rx_bits
);

    sample_t  tx_sample;
    tap_req_t ch_req;
    tap_req_t dfe_req;
    tap_rsp_t ch_rsp;
    tap_rsp_t dfe_rsp;
    logic     ch_grant;
    logic     dfe_grant;
    logic     ch_loaded;
    logic     dfe_loaded;

    assign taps_ready = ch_loaded & dfe_loaded; // both loaders done

    pam4_transmitter #(
        .prbs_seed (prbs_seed)
    ) u_tx (
        .clock     (clock),
        .reset_n   (reset_n),
        .enable    (run & taps_ready), // no samples before the taps are in
        .tx_sample (tx_sample)
    );

    isi_channel #(
        .num_channel_taps (num_channel_taps)
    ) u_channel (
        .clock       (clock),
        .reset_n     (reset_n),
        .load_taps   (load_taps),
        .tx_sample   (tx_sample),
        .tap_req     (ch_req),
        .tap_grant   (ch_grant),
        .tap_rsp     (ch_rsp),
        .taps_loaded (ch_loaded),
        .channel_out (channel_out)
    );

    dfe_receiver #(
        .num_dfe_taps  (num_dfe_taps),
        .dfe_base_addr (dfe_base_addr)
    ) u_dfe (
        .clock       (clock),
        .reset_n     (reset_n),
        .load_taps   (load_taps),
        .rx_sample   (channel_out), // no noise stage in between
        .tap_req     (dfe_req),
        .tap_grant   (dfe_grant),
        .tap_rsp     (dfe_rsp),
        .taps_loaded (dfe_loaded),
        .rx_bits     (rx_bits)
    );

    tap_memory_arbiter u_arbiter (
        .clock         (clock),
        .reset_n       (reset_n),
        .host_wr       (host_wr),
        .channel_req   (ch_req),
        .dfe_req       (dfe_req),
        .channel_grant (ch_grant),
        .dfe_grant     (dfe_grant),
        .channel_rsp   (ch_rsp),
        .dfe_rsp       (dfe_rsp)
    );

endmodule

/* testbench/serdes_link_tb.sv */
`timescale 1ns/1ps

module serdes_link_tb import serdes_pkg::*; ();

    localparam int num_samples = 120;  // rx samples per test
    localparam int ready_limit = 200;  // cycles allowed for a tap load
    localparam int run_limit   = 4000; // cycles allowed for one stream

    logic     clock;
    logic     reset_n;
    host_wr_t host_wr;
    logic     load_taps;
    logic     run;
    logic     taps_ready;
    sample_t  channel_out;
    bits_t    rx_bits;

    integer     seed;
    logic [6:0] ref_prbs;        // model of the tx prbs register
    int         tap_image [8];   // what the memory should hold
    int         ref_x [4];       // x(n) .. x(n-3)
    int         ref_d [1:3];     // past decisions
    int         exp_level_q [$];
    logic [1:0] exp_bits_q [$];
    logic [1:0] prbs_bits_q [$]; // transmitted pairs
    int         error_count;
    int         check_count;
    int         rx_count;
    int         sym_err_count;   // dut bits that differ from the prbs
    int         tests_run;
    int         err_base;
    int         rx_base;
    int         sym_base;
    bit         check_prbs;      // set where the link must be error free
    bit         timed_out;       // later waits are skipped once set

    serdes_link_top #(
        .num_channel_taps (4),
        .num_dfe_taps     (3),
        .dfe_base_addr    (4),
        .prbs_seed        (7'h7f)
    ) DUT (
        .clock       (clock),
        .reset_n     (reset_n),
        .host_wr     (host_wr),
        .load_taps   (load_taps),
        .run         (run),
        .taps_ready  (taps_ready),
        .channel_out (channel_out),
        .rx_bits     (rx_bits)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // gray pair to pam-4 level
    function automatic int level_of(logic [1:0] pair);
        case (pair)
            2'b00:   return -84;
            2'b01:   return -28;
            2'b11:   return 28;
            default: return 84;
        endcase
    endfunction

    function automatic int slice_level(int v);
        if (v >= 56) begin
            return 84;
        end else if (v >= 0) begin
            return 28;
        end else if (v >= -56) begin
            return -28;
        end
        return -84;
    endfunction

    function automatic logic [1:0] bits_of(int level);
        case (level)
            84:      return 2'b10;
            28:      return 2'b11;
            -28:     return 2'b01;
            default: return 2'b00;
        endcase
    endfunction

    // one symbol through prbs, fir and dfe, results queued in order
    function automatic void ref_step();
        logic [1:0] pair;
        int         acc;
        int         y;
        int         fb;
        int         dec;
        pair[1]  = ref_prbs[6] ^ ref_prbs[5]; // x^7 + x^6 + 1
        ref_prbs = {ref_prbs[5:0], pair[1]};
        pair[0]  = ref_prbs[6] ^ ref_prbs[5];
        ref_prbs = {ref_prbs[5:0], pair[0]};
        for (int k = 3; k > 0; k--) begin
            ref_x[k] = ref_x[k-1];
        end
        ref_x[0] = level_of(pair);
        acc = 0;
        for (int k = 0; k < 4; k++) begin
            acc += tap_image[k] * ref_x[k]; // h0..h3
        end
        y = acc >>> 6;
        if (y > 127) begin
            y = 127;
        end else if (y < -127) begin
            y = -127;
        end
        fb = 0;
        for (int k = 1; k <= 3; k++) begin
            fb += tap_image[3 + k] * ref_d[k]; // g1 at address 4
        end
        dec = slice_level(y - (fb >>> 6));
        ref_d[3] = ref_d[2];
        ref_d[2] = ref_d[1];
        ref_d[1] = dec;
        exp_level_q.push_back(y);
        exp_bits_q.push_back(bits_of(dec));
        prbs_bits_q.push_back(pair);
    endfunction

    task automatic check(string name, int actual, int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("[FAIL] %0t %s: got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic drive_slot();
        @(posedge clock);
        #1; // inputs move just after the edge
    endtask

    task automatic start_test();
        err_base = error_count;
        rx_base  = rx_count;
        sym_base = sym_err_count;
    endtask

    task automatic end_test(string name);
        tests_run++;
        $display("test %0d %s: %0d samples, %0d symbol errors, %0d check errors", tests_run,
                 name, rx_count - rx_base, sym_err_count - sym_base, error_count - err_base);
    endtask

    // host writes land while loaders sit idle or ready
    task automatic write_taps(int h0, int h1, int h2, int h3, int g1, int g2, int g3);
        int vals [7];
        vals = '{h0, h1, h2, h3, g1, g2, g3};
        for (int a = 0; a < 7; a++) begin
            drive_slot();
            host_wr.valid = 1'b1;
            host_wr.addr  = 3'(a);
            host_wr.tap   = 8'(vals[a]);
            tap_image[a]  = vals[a];
        end
        drive_slot();
        host_wr = '0;
    endtask

    task automatic wait_taps_ready();
        int cycles;
        cycles = 0;
        while (!timed_out && !taps_ready && cycles < ready_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!timed_out && !taps_ready) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: taps_ready still low after %0d cycles", ready_limit);
        end
    endtask

    task automatic reload();
        drive_slot();
        load_taps = 1'b1;
        drive_slot();
        load_taps = 1'b0;
        wait_taps_ready();
    endtask

    // run until n more rx samples, then let the three stages drain
    task automatic stream(int n, bit gaps);
        int target;
        int cycles;
        target = rx_count + n;
        cycles = 0;
        while (!timed_out && rx_count < target && cycles < run_limit) begin
            drive_slot();
            run = gaps ? (($random(seed) & 1) != 0) : 1'b1;
            cycles++;
        end
        drive_slot();
        run = 1'b0;
        if (!timed_out && rx_count < target) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d rx samples arrived", rx_count - target + n, n);
        end
        repeat (4) @(posedge clock); // tx, channel, dfe stages
        if (!timed_out) begin
            check("pending rx samples", exp_bits_q.size(), 0);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        logic [1:0] want_bits;
        logic [1:0] prbs_pair;
        if (reset_n) begin
            if (rx_bits.valid) begin
                if (exp_bits_q.size() == 0) begin
                    error_count++;
                    $display("rx_bits valid at %0t with no sample sent", $time);
                end else begin
                    want_bits = exp_bits_q.pop_front();
                    prbs_pair = prbs_bits_q.pop_front();
                    check("rx_bits.bits", int'(rx_bits.bits), int'(want_bits));
                    if (rx_bits.bits != prbs_pair) begin
                        sym_err_count++;
                    end
                    if (check_prbs) begin
                        check("rx_bits.bits vs prbs", int'(rx_bits.bits), int'(prbs_pair));
                    end
                    rx_count++;
                end
            end
            if (channel_out.valid) begin
                ref_step(); // next symbol of the model
                check("channel_out.level", int'($signed(channel_out.level)),
                      exp_level_q.pop_front());
            end
        end
    end

    initial begin
        int addr;
        seed          = 32'hfe9820b1;
        reset_n       = 1'b0;
        host_wr       = '0;
        load_taps     = 1'b0;
        run           = 1'b0;
        check_prbs    = 1'b0;
        timed_out     = 1'b0;
        ref_prbs      = 7'h7f;
        error_count   = 0;
        check_count   = 0;
        rx_count      = 0;
        sym_err_count = 0;
        tests_run     = 0;
        for (int k = 0; k < 8; k++) begin
            tap_image[k] = 0;
        end
        for (int k = 0; k < 4; k++) begin
            ref_x[k] = 0;
        end
        for (int k = 1; k <= 3; k++) begin
            ref_d[k] = 0;
        end
        repeat (2) @(posedge clock);
        #1 reset_n = 1'b1;

        // nothing may move before a tap load, even with run high
        start_test();
        run = 1'b1;
        repeat (20) begin
            @(negedge clock);
            check("taps_ready", int'(taps_ready), 0);
            check("channel_out.valid", int'(channel_out.valid), 0);
            check("rx_bits.valid", int'(rx_bits.valid), 0);
        end
        drive_slot();
        run = 1'b0;
        end_test("reset state");

        start_test();
        write_taps(64, 0, 0, 0, 0, 0, 0);
        reload();
        check_prbs = 1'b1;
        stream(num_samples, 1'b0);
        check_prbs = 1'b0;
        end_test("ideal link");

        start_test();
        write_taps(64, 24, 8, 0, 24, 8, 0); // dfe matches the post-cursors
        reload();
        check_prbs = 1'b1;
        stream(num_samples, 1'b0);
        check_prbs = 1'b0;
        end_test("isi cancelled");

        start_test();
        write_taps(64, 48, 32, 16, 0, 0, 0); // saturates, slicer errs
        reload();
        stream(num_samples, 1'b0);
        check("symbol errors seen", int'(sym_err_count > sym_base), 1);
        end_test("uncorrected isi");

        // host traffic keeps stealing the memory port during the load
        start_test();
        write_taps(64, 16, 0, 0, 16, 0, 0);
        for (int i = 0; i < 24; i++) begin
            drive_slot();
            load_taps = (i == 2);
            if (i == 3) begin
                check("taps_ready after reload", int'(taps_ready), 0);
            end
            addr          = $random(seed) & 7;
            host_wr.valid = (($random(seed) & 3) != 0);
            host_wr.addr  = 3'(addr);
            host_wr.tap   = (addr == 7) ? 8'($random(seed)) : 8'(tap_image[addr]); // same taps
        end
        drive_slot();
        host_wr = '0;
        wait_taps_ready();
        stream(num_samples, 1'b0);
        end_test("reload with contention");

        start_test();
        stream(num_samples, 1'b1); // run toggles at random
        end_test("run gaps");

        finish_run();
    end

endmodule

/* project.f */
rtl/serdes_pkg.sv
rtl/pam4_transmitter.sv
rtl/isi_channel.sv
rtl/dfe_receiver.sv
rtl/tap_memory_arbiter.sv
rtl/serdes_link_top.sv
testbench/serdes_link_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the serdes link testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module serdes_link_tb \
    -f project.f \
    -o serdes_link_sim

./obj_dir/serdes_link_sim | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
